// ==== hdl/usrp_cfg.svh ====
// Register addresses are 7 bits wide; FIFO depths must be powers of two
`ifndef USRP_CFG_SVH
`define USRP_CFG_SVH

// Settings register addresses
`define FR_ENABLE       7'd2
`define FR_MODE         7'd13
`define FR_INTERP_RATE  7'd32
`define FR_DECIM_RATE   7'd33
`define FR_TX_MUX       7'd38

// FR_ENABLE layout: bit 0 enables transmit, bit 1 enables receive
// FR_MODE layout: bit 0 loopback, bit 1 debug counter

// Receive FIFO depth in 16-bit words
`define RX_FIFO_DEPTH   64

// Fill level at which a packet is ready for the host
`define RX_PKT_WORDS    8

// Transmit FIFO depth in I/Q pairs
`define TX_FIFO_DEPTH   16

`endif

// ==== hdl/usrp_pkg.sv ====
// Shared datapath types; only one I/Q pair exists per direction
package usrp_pkg;

   // Settings write, valid for one clk64 cycle while strobe is high
   typedef struct packed {
      logic        strobe;
      logic [6:0]  addr;
      logic [31:0] data;
   } serial_bus_s;

   // One complex sample
   typedef struct packed {
      logic [15:0] i;
      logic [15:0] q;
   } iq_s;

   // DAC routing view of a settings word
   typedef struct packed {
      logic [11:0] pad;
      logic [3:0]  dac3mux;
      logic [3:0]  dac2mux;
      logic [3:0]  dac1mux;
      logic [3:0]  dac0mux;
      logic        tx_realsignals;
      logic [2:0]  tx_numchan;
   } txmux_s;

   // Mode view of a settings word
   typedef struct packed {
      logic [29:0] pad;
      logic        counter;
      logic        loopback;
   } mode_s;

   typedef union packed {
      txmux_s txmux;
      mode_s  mode;
   } setting_word_u;

   // Control registers as the datapath sees them
   typedef struct packed {
      logic       enable_rx;
      logic       enable_tx;
      logic       counter;
      logic       loopback;
      logic [3:0] dac3mux;
      logic [3:0] dac2mux;
      logic [3:0] dac1mux;
      logic [3:0] dac0mux;
   } ctrl_s;

endpackage

// ==== hdl/master_control.sv ====
// Writes take effect one clock after the strobe; rates use the low 8 bits only
`timescale 1ns/1ns
`include "usrp_cfg.svh"

module master_control (
   input  logic                  clk64,
   input  logic                  rx_dsp_reset,
   input  usrp_pkg::serial_bus_s i_bus,
   output usrp_pkg::ctrl_s       o_ctrl,
   output logic                  o_strobe_decim,
   output logic                  o_strobe_interp,
   output logic                  o_tx_sample_strobe
);
   import usrp_pkg::*;

   setting_word_u   word;
   // Index 0 is decimation, index 1 is interpolation
   logic [1:0][7:0] rate;
   logic [1:0][7:0] rate_cnt;
   logic [1:0]      rate_en;

   assign word = i_bus.data;

   // Register decode
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         o_ctrl <= '0;
         rate   <= '0;
      end
      else if (i_bus.strobe)
      begin
         case (i_bus.addr)
            `FR_MODE:
            begin
               o_ctrl.counter  <= word.mode.counter;
               o_ctrl.loopback <= word.mode.loopback;
            end
            `FR_TX_MUX:
            begin
               o_ctrl.dac0mux <= word.txmux.dac0mux;
               o_ctrl.dac1mux <= word.txmux.dac1mux;
               o_ctrl.dac2mux <= word.txmux.dac2mux;
               o_ctrl.dac3mux <= word.txmux.dac3mux;
            end
            `FR_DECIM_RATE:
               rate[0] <= i_bus.data[7:0];
            `FR_INTERP_RATE:
               rate[1] <= i_bus.data[7:0];
            `FR_ENABLE:
            begin
               o_ctrl.enable_tx <= i_bus.data[0];
               o_ctrl.enable_rx <= i_bus.data[1];
            end
            default:
            begin
            end
         endcase
      end
   end

   assign rate_en = {o_ctrl.enable_tx, o_ctrl.enable_rx};

   // Down-counters reload from the rate, so one pulse every rate+1 cycles
   always_ff @(posedge clk64)
   begin
      for (int k = 0; k < 2; k++)
      begin
         if (rx_dsp_reset || !rate_en[k])
            rate_cnt[k] <= '0;
         else if (rate_cnt[k] == 8'd0)
            rate_cnt[k] <= rate[k];
         else
            rate_cnt[k] <= rate_cnt[k] - 8'd1;
      end
   end

   assign o_strobe_decim  = rate_en[0] && (rate_cnt[0] == 8'd0);
   assign o_strobe_interp = rate_en[1] && (rate_cnt[1] == 8'd0);

   // DAC interleave phase, parked low while transmit is off
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || !o_ctrl.enable_tx)
         o_tx_sample_strobe <= 1'b0;
      else
         o_tx_sample_strobe <= ~o_tx_sample_strobe;
   end

endmodule

// ==== hdl/tx_path.sv ====
// Full FIFO drops pushes, empty FIFO yields zeros; mux bits 2 and 1 are ignored
`timescale 1ns/1ns
`include "usrp_cfg.svh"

module tx_path (
   input  logic            clk64,
   input  logic            rx_dsp_reset,
   input  usrp_pkg::ctrl_s i_ctrl,
   input  logic            i_tx_wr,
   input  usrp_pkg::iq_s   i_tx_sample,
   input  logic            i_strobe_interp,
   input  logic            i_tx_sample_strobe,
   input  logic            i_clear_status,
   output usrp_pkg::iq_s   o_tx_bb,
   output logic [13:0]     o_tx_a,
   output logic [13:0]     o_tx_b,
   output logic            o_txsync,
   output logic            o_tx_underrun
);
   import usrp_pkg::*;

   localparam int DEPTH = `TX_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   iq_s           mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          push;
   logic          pop;
   logic          empty;
   logic [15:0]   dac_sel [4];

   // Bit 3 drives the DAC, bit 0 picks Q over I
   function automatic logic [15:0] route(input logic [3:0] mux, input iq_s s);
      if (!mux[3])
         return 16'd0;
      return mux[0] ? s.q : s.i;
   endfunction

   assign empty = (count == '0);
   assign push  = i_tx_wr && (count != DEPTH[AW:0]);
   assign pop   = i_strobe_interp && !empty;

   always_ff @(posedge clk64)
   begin
      if (push)
         mem[wr_ptr] <= i_tx_sample;
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         o_tx_bb       <= '0;
         o_tx_underrun <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
         // Interpolation strobe takes a pair, or zeros when starved
         if (pop)
            o_tx_bb <= mem[rd_ptr];
         else if (i_strobe_interp)
            o_tx_bb <= '0;
         if (i_clear_status)
            o_tx_underrun <= 1'b0;
         else if (i_strobe_interp && empty)
            o_tx_underrun <= 1'b1;
      end
   end

   assign dac_sel[0] = route(i_ctrl.dac0mux, o_tx_bb);
   assign dac_sel[1] = route(i_ctrl.dac1mux, o_tx_bb);
   assign dac_sel[2] = route(i_ctrl.dac2mux, o_tx_bb);
   assign dac_sel[3] = route(i_ctrl.dac3mux, o_tx_bb);

   // Each DAC port alternates between two slots, top 14 bits only
   assign o_tx_a   = i_tx_sample_strobe ? dac_sel[1][15:2] : dac_sel[0][15:2];
   assign o_tx_b   = i_tx_sample_strobe ? dac_sel[3][15:2] : dac_sel[2][15:2];
   assign o_txsync = i_tx_sample_strobe;

endmodule

// ==== hdl/rx_source_select.sv ====
// Counter mode wins over loopback; loopback holds the last popped transmit pair
`timescale 1ns/1ns

module rx_source_select (
   input  logic            clk64,
   input  logic            rx_dsp_reset,
   input  usrp_pkg::ctrl_s i_ctrl,
   input  logic            i_hb_strobe,
   input  usrp_pkg::iq_s   i_dec_sample,
   input  usrp_pkg::iq_s   i_tx_bb,
   input  logic            i_strobe_interp,
   output usrp_pkg::iq_s   o_rx_ch
);
   import usrp_pkg::*;

   logic [15:0] debug_counter;
   logic        interp_d;
   iq_s         loopback;

   // Debug ramp, two steps per receive pair
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || !i_ctrl.enable_rx)
         debug_counter <= 16'd0;
      else if (i_hb_strobe)
         debug_counter <= debug_counter + 16'd2;
   end

   // tx_bb updates on the strobe edge, so sample it a cycle later
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         interp_d <= 1'b0;
         loopback <= '0;
      end
      else
      begin
         interp_d <= i_strobe_interp;
         if (interp_d)
            loopback <= i_tx_bb;
      end
   end

   always_comb
   begin
      if (i_ctrl.counter)
         o_rx_ch = '{i: debug_counter, q: debug_counter + 16'd1};
      else if (i_ctrl.loopback)
         o_rx_ch = loopback;
      else
         o_rx_ch = i_dec_sample;
   end

endmodule

// ==== hdl/rx_decimator.sv ====
// Output is the plain sum of rate+1 samples cut to 16 bits, no gain correction
`timescale 1ns/1ns

module rx_decimator (
   input  logic          clk64,
   input  logic          rx_dsp_reset,
   input  logic [11:0]   i_rx_a,
   input  logic [11:0]   i_rx_b,
   input  logic          i_strobe_decim,
   output usrp_pkg::iq_s o_sample,
   output logic          o_hb_strobe
);
   import usrp_pkg::*;

   // 256 samples of 12 bits fit in 20 bits, 24 leaves margin
   logic [1:0][23:0] acc;
   logic [1:0][23:0] acc_next;
   logic [1:0][11:0] adc;

   // Channel 0 is I, channel 1 is Q
   assign adc = {i_rx_b, i_rx_a};

   always_comb
   begin
      for (int k = 0; k < 2; k++)
         acc_next[k] = acc[k] + {{12{adc[k][11]}}, adc[k]};
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         acc         <= '0;
         o_sample    <= '0;
         o_hb_strobe <= 1'b0;
      end
      else
      begin
         o_hb_strobe <= i_strobe_decim;
         if (i_strobe_decim)
         begin
            // Dump includes this cycle's sample, then start over
            o_sample.i <= acc_next[0][15:0];
            o_sample.q <= acc_next[1][15:0];
            acc        <= '0;
         end
         else
            acc <= acc_next;
      end
   end

endmodule

// ==== hdl/rx_buffer.sv ====
// Writes I then Q on the next cycle, so decimation rate must be at least 1
`timescale 1ns/1ns
`include "usrp_cfg.svh"

module rx_buffer (
   input  logic          clk64,
   input  logic          rx_dsp_reset,
   input  logic          i_enable_rx,
   input  logic          i_hb_strobe,
   input  usrp_pkg::iq_s i_ch,
   input  logic          i_rd,
   input  logic          i_clear_status,
   output logic [15:0]   o_rx_data,
   output logic          o_have_pkt_rdy,
   output logic          o_rx_overrun
);
   localparam int DEPTH = `RX_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   logic [15:0]   mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic [15:0]   q_hold;
   logic          q_pend;
   logic          wr_req;
   logic [15:0]   wr_word;
   logic          full;
   logic          do_wr;
   logic          do_rd;

   // Q waits one cycle behind its I
   assign wr_req  = q_pend || (i_hb_strobe && i_enable_rx);
   assign wr_word = q_pend ? q_hold : i_ch.i;

   assign full  = (count == DEPTH[AW:0]);
   assign do_wr = wr_req && !full;
   assign do_rd = i_rd && (count != '0);

   always_ff @(posedge clk64)
   begin
      if (i_hb_strobe)
         q_hold <= i_ch.q;
      if (do_wr)
         mem[wr_ptr] <= wr_word;
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         q_pend       <= 1'b0;
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         o_rx_overrun <= 1'b0;
      end
      else
      begin
         q_pend <= i_hb_strobe && i_enable_rx;
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
         // Sticky until the host clears it
         if (i_clear_status)
            o_rx_overrun <= 1'b0;
         else if (wr_req && full)
            o_rx_overrun <= 1'b1;
      end
   end

   // First-word fall-through read port
   assign o_rx_data      = mem[rd_ptr];
   assign o_have_pkt_rdy = (count >= (AW + 1)'(`RX_PKT_WORDS));

endmodule

// ==== hdl/usrp_core.sv ====
// Single clk64 domain; reads and writes are one-cycle strobes with no handshake
`timescale 1ns/1ns

module usrp_core (
   input  logic                  clk64,
   input  logic                  rx_dsp_reset,
   input  usrp_pkg::serial_bus_s i_bus,
   input  logic [11:0]           i_rx_a,
   input  logic [11:0]           i_rx_b,
   input  logic                  i_tx_wr,
   input  usrp_pkg::iq_s         i_tx_sample,
   input  logic                  i_rd,
   input  logic                  i_clear_status,
   output logic [15:0]           o_rx_data,
   output logic                  o_have_pkt_rdy,
   output logic                  o_rx_overrun,
   output logic [13:0]           o_tx_a,
   output logic [13:0]           o_tx_b,
   output logic                  o_txsync,
   output logic                  o_tx_underrun
);
   import usrp_pkg::*;

   ctrl_s ctrl;
   logic  strobe_decim;
   logic  strobe_interp;
   logic  tx_sample_strobe;
   logic  hb_strobe;
   iq_s   dec_sample;
   iq_s   tx_bb;
   iq_s   rx_ch;

   master_control master_control_i (
      .clk64              (clk64),
      .rx_dsp_reset       (rx_dsp_reset),
      .i_bus              (i_bus),
      .o_ctrl             (ctrl),
      .o_strobe_decim     (strobe_decim),
      .o_strobe_interp    (strobe_interp),
      .o_tx_sample_strobe (tx_sample_strobe)
   );

   // Transmit side
   tx_path tx_path_i (
      .clk64              (clk64),
      .rx_dsp_reset       (rx_dsp_reset),
      .i_ctrl             (ctrl),
      .i_tx_wr            (i_tx_wr),
      .i_tx_sample        (i_tx_sample),
      .i_strobe_interp    (strobe_interp),
      .i_tx_sample_strobe (tx_sample_strobe),
      .i_clear_status     (i_clear_status),
      .o_tx_bb            (tx_bb),
      .o_tx_a             (o_tx_a),
      .o_tx_b             (o_tx_b),
      .o_txsync           (o_txsync),
      .o_tx_underrun      (o_tx_underrun)
   );

   // Receive side
   rx_decimator rx_decimator_i (
      .clk64          (clk64),
      .rx_dsp_reset   (rx_dsp_reset),
      .i_rx_a         (i_rx_a),
      .i_rx_b         (i_rx_b),
      .i_strobe_decim (strobe_decim),
      .o_sample       (dec_sample),
      .o_hb_strobe    (hb_strobe)
   );

   rx_source_select rx_source_select_i (
      .clk64           (clk64),
      .rx_dsp_reset    (rx_dsp_reset),
      .i_ctrl          (ctrl),
      .i_hb_strobe     (hb_strobe),
      .i_dec_sample    (dec_sample),
      .i_tx_bb         (tx_bb),
      .i_strobe_interp (strobe_interp),
      .o_rx_ch         (rx_ch)
   );

   rx_buffer rx_buffer_i (
      .clk64          (clk64),
      .rx_dsp_reset   (rx_dsp_reset),
      .i_enable_rx    (ctrl.enable_rx),
      .i_hb_strobe    (hb_strobe),
      .i_ch           (rx_ch),
      .i_rd           (i_rd),
      .i_clear_status (i_clear_status),
      .o_rx_data      (o_rx_data),
      .o_have_pkt_rdy (o_have_pkt_rdy),
      .o_rx_overrun   (o_rx_overrun)
   );

endmodule

// ==== bench/usrp_core_tb.sv ====
// Needs hdl/ on the include path; the receive word count assumes the rate is set before enable
`timescale 1ns/1ns
`include "usrp_cfg.svh"

module usrp_core_tb;
   import usrp_pkg::*;

   logic        clk64 = 1'b0;
   logic        rx_dsp_reset;
   serial_bus_s bus;
   logic [11:0] rx_a;
   logic [11:0] rx_b;
   logic        tx_wr;
   iq_s         tx_sample;
   logic        rd;
   logic        clear_status;
   logic [15:0] rx_data;
   logic        have_pkt_rdy;
   logic        rx_overrun;
   logic [13:0] tx_a;
   logic [13:0] tx_b;
   logic        txsync;
   logic        tx_underrun;

   int          errors = 0;
   int          tests = 0;
   int          test_start;
   int          written;
   int          reads;
   bit          track_pkt = 1'b0;
   logic [31:0] rng = 32'hf102;
   bit          rx_en_ref = 1'b0;
   int          decim_ref = 0;
   int          rx_cycles = 0;

   usrp_core dut_i (
      .clk64 (clk64), .rx_dsp_reset (rx_dsp_reset), .i_bus (bus),
      .i_rx_a (rx_a), .i_rx_b (rx_b), .i_tx_wr (tx_wr), .i_tx_sample (tx_sample),
      .i_rd (rd), .i_clear_status (clear_status), .o_rx_data (rx_data),
      .o_have_pkt_rdy (have_pkt_rdy), .o_rx_overrun (rx_overrun), .o_tx_a (tx_a),
      .o_tx_b (tx_b), .o_txsync (txsync), .o_tx_underrun (tx_underrun)
   );

   always #5 clk64 = ~clk64;

   // Reference word count, one pair per decimation period after enable
   always @(negedge clk64)
   begin
      if (rx_en_ref)
      begin
         if (rx_cycles >= 1 && (rx_cycles - 1) % (decim_ref + 1) == 0)
            written += 2;
         rx_cycles++;
      end
      if (track_pkt)
         assert (!have_pkt_rdy || (written - reads >= `RX_PKT_WORDS))
         else
         begin
            $display("packet ready high with only %0d unread words at %0t",
                     written - reads, $time);
            errors++;
         end
   end

   // Status flags hold until a clear
   assert property (@(posedge clk64) disable iff (rx_dsp_reset)
                    (rx_overrun && !clear_status) |=> rx_overrun)
   else
   begin
      $display("error at %0t: o_rx_overrun is 0, expected 1", $time);
      errors++;
   end

   assert property (@(posedge clk64) disable iff (rx_dsp_reset)
                    (tx_underrun && !clear_status) |=> tx_underrun)
   else
   begin
      $display("error at %0t: o_tx_underrun is 0, expected 1", $time);
      errors++;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [13:0] dac_a(input iq_s p, input logic sync);
      return sync ? p.q[15:2] : p.i[15:2];
   endfunction

   function automatic logic [13:0] dac_b(input iq_s p, input logic sync);
      return sync ? p.i[15:2] : 14'd0;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic apply_reset();
      @(posedge clk64);
      rx_dsp_reset <= 1'b1;
      bus          <= '0;
      tx_wr        <= 1'b0;
      rd           <= 1'b0;
      clear_status <= 1'b0;
      repeat (8) @(posedge clk64);
      rx_dsp_reset <= 1'b0;
      rx_en_ref = 1'b0;
      decim_ref = 0;
      rx_cycles = 0;
      written   = 0;
      reads     = 0;
   endtask

   task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
      @(posedge clk64);
      bus <= '{1'b1, addr, data};
      @(posedge clk64);
      bus.strobe <= 1'b0;
      // Register takes its new value on this edge
      if (addr == `FR_ENABLE)
      begin
         rx_en_ref = data[1];
         rx_cycles = 0;
      end
      else if (addr == `FR_DECIM_RATE)
         decim_ref = data[7:0];
   endtask

   task automatic wait_pkt(output bit ok);
      int n;
      ok = 1'b0;
      n  = 0;
      while (!ok && n < 300)
      begin
         @(negedge clk64);
         ok = have_pkt_rdy;
         n++;
      end
      if (!ok)
      begin
         $display("timeout at %0t: packet ready never rose", $time);
         errors++;
      end
   endtask

   // FWFT head is sampled first, then popped
   task automatic read_word(output logic [15:0] w);
      @(negedge clk64);
      w = rx_data;
      @(posedge clk64);
      rd <= 1'b1;
      @(posedge clk64);
      rd <= 1'b0;
      reads++;
   endtask

   task automatic begin_test();
      test_start = errors;
      tests++;
   endtask

   task automatic end_test(input string name);
      $display("%s: %0d errors", name, errors - test_start);
   endtask

   task automatic reset_and_flags();
      bit prev;
      begin_test();
      apply_reset();
      @(negedge clk64);
      check("o_have_pkt_rdy", have_pkt_rdy, 0);
      check("o_rx_overrun", rx_overrun, 0);
      check("o_tx_underrun", tx_underrun, 0);
      check("o_txsync", txsync, 0);
      write_reg(`FR_ENABLE, 32'h1);
      @(negedge clk64);
      prev = txsync;
      repeat (10)
      begin
         @(negedge clk64);
         check("o_txsync", txsync, !prev);
         prev = txsync;
      end
      end_test("reset and flags");
   endtask

   task automatic counter_sequence();
      bit          ok;
      logic [15:0] w;
      begin_test();
      apply_reset();
      track_pkt = 1'b1;
      write_reg(`FR_DECIM_RATE, 32'd3);
      write_reg(`FR_MODE, 32'h2);
      write_reg(`FR_ENABLE, 32'h2);
      for (int k = 0; k < 40; k++)
      begin
         wait_pkt(ok);
         if (!ok)
            break;
         read_word(w);
         check("o_rx_data", w, k);
      end
      track_pkt = 1'b0;
      end_test("counter mode");
   endtask

   task automatic decimation(input int d);
      bit          ok;
      logic [15:0] wi;
      logic [15:0] wq;
      logic [31:0] exp_i;
      logic [31:0] exp_q;
      begin_test();
      rng = xorshift(rng);
      rx_a <= rng[11:0];
      rx_b <= rng[27:16];
      apply_reset();
      exp_i = (d + 1) * $signed({{20{rx_a[11]}}, rx_a});
      exp_q = (d + 1) * $signed({{20{rx_b[11]}}, rx_b});
      write_reg(`FR_DECIM_RATE, d);
      write_reg(`FR_ENABLE, 32'h2);
      for (int p = 0; p < 6; p++)
      begin
         wait_pkt(ok);
         if (!ok)
            break;
         read_word(wi);
         read_word(wq);
         // The first dump holds whatever summed before enable
         if (p > 0)
         begin
            check("o_rx_data (I)", wi, exp_i[15:0]);
            check("o_rx_data (Q)", wq, exp_q[15:0]);
         end
      end
      end_test($sformatf("decimation by %0d", d + 1));
   endtask

   task automatic overrun_and_clear();
      int          n;
      logic [15:0] w;
      begin_test();
      apply_reset();
      write_reg(`FR_DECIM_RATE, 32'd3);
      write_reg(`FR_MODE, 32'h2);
      write_reg(`FR_ENABLE, 32'h2);
      n = 0;
      while (!rx_overrun && n < 400)
      begin
         @(negedge clk64);
         n++;
      end
      if (!rx_overrun)
      begin
         $display("timeout at %0t: overrun never rose", $time);
         errors++;
      end
      assert (written > `RX_FIFO_DEPTH)
      else
      begin
         $display("overrun rose after only %0d words", written);
         errors++;
      end
      // Slow the writes, free some room, then clear
      write_reg(`FR_DECIM_RATE, 32'd15);
      repeat (4) read_word(w);
      @(posedge clk64);
      clear_status <= 1'b1;
      @(posedge clk64);
      clear_status <= 1'b0;
      @(negedge clk64);
      check("o_rx_overrun", rx_overrun, 0);
      repeat (20)
      begin
         read_word(w);
         check("o_rx_overrun", rx_overrun, 0);
      end
      end_test("overrun and clear");
   endtask

   task automatic tx_routing();
      iq_s seq [6];
      int  idx;
      int  after;
      int  n;
      begin_test();
      apply_reset();
      seq[0] = '0;
      seq[5] = '0;
      for (int k = 1; k < 5; k++)
         seq[k] = '{i: 16'h1234 * k, q: 16'h4321 * k + 16'h0010};
      for (int k = 1; k < 5; k++)
      begin
         @(posedge clk64);
         tx_wr     <= 1'b1;
         tx_sample <= seq[k];
      end
      @(posedge clk64);
      tx_wr <= 1'b0;
      // dac3 and dac0 take I, dac1 takes Q, dac2 stays undriven
      write_reg(`FR_TX_MUX, 32'h0008_0980);
      write_reg(`FR_INTERP_RATE, 32'd7);
      write_reg(`FR_ENABLE, 32'h1);
      idx   = 0;
      after = 0;
      n     = 0;
      while (after < 6 && n < 400)
      begin
         @(negedge clk64);
         n++;
         if (idx < 5 && tx_a == dac_a(seq[idx + 1], txsync) &&
             tx_b == dac_b(seq[idx + 1], txsync))
            idx++;
         check("o_tx_a", tx_a, dac_a(seq[idx], txsync));
         check("o_tx_b", tx_b, dac_b(seq[idx], txsync));
         if (tx_underrun)
         begin
            after++;
            assert (idx == 5)
            else
            begin
               $display("underrun at %0t before all pairs were sent", $time);
               errors++;
            end
         end
      end
      if (after == 0)
      begin
         $display("timeout at %0t: underrun never rose", $time);
         errors++;
      end
      end_test("transmit routing and underrun");
   endtask

   task automatic loopback_pair();
      bit          ok;
      int          seen;
      logic [15:0] wi;
      logic [15:0] wq;
      iq_s         pair;
      begin_test();
      apply_reset();
      pair = '{i: 16'h5a3c, q: 16'hc3a5};
      write_reg(`FR_DECIM_RATE, 32'd3);
      write_reg(`FR_INTERP_RATE, 32'd3);
      write_reg(`FR_MODE, 32'h1);
      @(posedge clk64);
      tx_wr     <= 1'b1;
      tx_sample <= pair;
      write_reg(`FR_ENABLE, 32'h3);
      seen = 0;
      for (int p = 0; p < 20 && seen < 4; p++)
      begin
         wait_pkt(ok);
         if (!ok)
            break;
         read_word(wi);
         read_word(wq);
         if ({wi, wq} == pair)
            seen++;
         else
            check("loopback pair", {wi, wq}, 32'h0);
      end
      if (seen == 0)
      begin
         $display("loopback pair never reached the receive FIFO");
         errors++;
      end
      @(posedge clk64);
      tx_wr <= 1'b0;
      end_test("loopback");
   endtask

   initial
   begin
      rx_dsp_reset = 1'b1;
      bus          = '0;
      rx_a         = '0;
      rx_b         = '0;
      tx_wr        = 1'b0;
      tx_sample    = '0;
      rd           = 1'b0;
      clear_status = 1'b0;
      reset_and_flags();
      counter_sequence();
      decimation(3);
      decimation(7);
      overrun_and_clear();
      tx_routing();
      loopback_pair();
      $display("%0d tests, %0d errors", tests, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/usrp_pkg.sv
hdl/master_control.sv
hdl/tx_path.sv
hdl/rx_source_select.sv
hdl/rx_decimator.sv
hdl/rx_buffer.sv
hdl/usrp_core.sv
bench/usrp_core_tb.sv

// ==== Bender.yml ====
package:
  name: usrp_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/usrp_pkg.sv
      - hdl/master_control.sv
      - hdl/tx_path.sv
      - hdl/rx_source_select.sv
      - hdl/rx_decimator.sv
      - hdl/rx_buffer.sv
      - hdl/usrp_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/usrp_core_tb.sv
